//--- hdl/sCurvePkg.sv
package sCurvePkg;

  typedef logic [15:0] dataWord_t;

  localparam dataWord_t ScanHeader = 16'h5343; // "SC" in ASCII
  localparam dataWord_t ScanTail   = 16'hFF45;

  localparam int ConfigBits   = 266; // Width of scConfig_t
  localparam int PulseCount   = 32;  // Test pulses per scan point
  localparam int PulseSpacing = 8;   // Clk cycles between test pulses
  localparam int FifoDepth    = 8;

  ////////////////////
  // ASIC slow-control frame, MSB leaves first
  typedef struct packed {
    logic [63:0]  ctestChannels; // One test-charge switch per channel
    logic [9:0]   vthDac;        // Already bit-reversed, LSB on the wire first
    logic [191:0] discriMask;    // Three discriminators per channel, 1 = enabled
  } scConfig_t;

  ////////////////////
  // Scan parameters from the host
  typedef struct packed {
    logic       singleChannel; // 0 = sweep channels 0 to 63
    logic [5:0] testChannel;
    logic       ctestInject;   // 0 = charge on the input pin, no ctest bits
    logic       unmaskAll;
    logic [9:0] startDac;
    logic [9:0] endDac;        // Must be reachable from startDac in dacStep steps
    logic [9:0] dacStep;
    logic [2:0] asicCount;     // ASICs in the daisy chain
    logic [2:0] testAsic;
    logic [7:0] suppressWidth; // In Clk cycles
  } scanSettings_t;

endpackage

//--- hdl/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
  parameter type payload_t = logic [15:0],
  parameter int  Depth     = 8
) (
  input  logic     Clk,
  input  logic     reset_n,
  input  logic     Write,
  input  payload_t WriteData,
  input  logic     Read,
  output payload_t ReadData,
  output logic     Empty,
  output logic     Full
);

  logic [$clog2(Depth)-1:0] wrPtr;
  logic [$clog2(Depth)-1:0] rdPtr;
  logic [$clog2(Depth):0]   count;
  payload_t                 mem [Depth];

  assign Empty = (count == '0);
  assign Full  = (int'(count) == Depth);

  // Storage and registered read port
  always_ff @(posedge Clk) begin
    if (Write) begin
      mem[wrPtr] <= WriteData;
    end
    if (Read) begin
      ReadData <= mem[rdPtr];
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (Write) begin
        wrPtr <= (int'(wrPtr) == Depth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (Read) begin
        rdPtr <= (int'(rdPtr) == Depth - 1) ? '0 : rdPtr + 1'b1;
      end
      case ({Write, Read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assert property (@(posedge Clk) disable iff (!reset_n) Write |-> !Full)
    else $error("FIFO write while full");
  assert property (@(posedge Clk) disable iff (!reset_n) Read |-> !Empty)
    else $error("FIFO read while empty");

endmodule

//--- hdl/slowControlLoader.sv
`timescale 1ns/1ps

module slowControlLoader (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 LoadStart,
  input  sCurvePkg::scConfig_t Config,
  output logic                 ScClk,
  output logic                 ScData,
  output logic                 LoadDone
);
  import sCurvePkg::*;

  logic                          busy;
  logic [$clog2(ConfigBits)-1:0] bitCnt;
  logic [ConfigBits-1:0]         shiftReg;

  // Frame is captured so the controller may move on
  always_ff @(posedge Clk) begin
    if (LoadStart) begin
      shiftReg <= Config;
    end else if (busy) begin
      shiftReg <= {shiftReg[ConfigBits-2:0], 1'b0};
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      busy     <= 1'b0;
      bitCnt   <= '0;
      ScClk    <= 1'b0;
      ScData   <= 1'b0;
      LoadDone <= 1'b0;
    end else begin
      ScClk    <= 1'b0;
      LoadDone <= 1'b0;
      if (LoadStart) begin
        busy   <= 1'b1;
        bitCnt <= '0;
      end else if (busy) begin
        ScClk  <= 1'b1;                     // Chain samples ScData on this strobe
        ScData <= shiftReg[ConfigBits-1];
        bitCnt <= bitCnt + 1'b1;
        if (int'(bitCnt) == ConfigBits - 1) begin
          busy     <= 1'b0;
          LoadDone <= 1'b1;                 // Last bit goes out with done
        end
      end
    end
  end

  // Controller must wait for LoadDone before the next frame
  assert property (@(posedge Clk) disable iff (!reset_n) LoadStart |-> !busy)
    else $error("LoadStart while a load is busy");

endmodule

//--- hdl/triggerCounter.sv
`timescale 1ns/1ps

module triggerCounter (
  input  logic                 Clk,
  input  logic                 reset_n,
  input  logic                 PointStart,
  output logic                 CtestPulse,
  input  logic [63:0]          Trigger,
  output logic                 CountWrite,
  output sCurvePkg::dataWord_t CountData,
  output logic                 PointDone
);
  import sCurvePkg::*;

  logic                            active;
  logic [$clog2(PulseSpacing)-1:0] spacingCnt;
  logic [$clog2(PulseCount):0]     pulseCnt;
  logic                            windowEnd;
  dataWord_t                       trigCnt;
  dataWord_t                       trigNext;

  // One event per cycle with any trigger, saturating
  always_comb begin
    trigNext = trigCnt;
    if (|Trigger && trigCnt != '1) begin
      trigNext = trigCnt + 16'd1;
    end
  end

  // Closes one spacing after the last pulse
  assign windowEnd = active && int'(pulseCnt) == PulseCount &&
                     int'(spacingCnt) == PulseSpacing - 1;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      active     <= 1'b0;
      spacingCnt <= '0;
      pulseCnt   <= '0;
      trigCnt    <= '0;
      CtestPulse <= 1'b0;
      CountWrite <= 1'b0;
      PointDone  <= 1'b0;
    end else begin
      CtestPulse <= 1'b0;
      CountWrite <= 1'b0;
      PointDone  <= CountWrite; // Count is in the FIFO by now
      if (PointStart) begin
        active     <= 1'b1;
        spacingCnt <= '0;
        pulseCnt   <= '0;
        trigCnt    <= '0;
      end else if (active) begin
        trigCnt    <= trigNext;
        spacingCnt <= (int'(spacingCnt) == PulseSpacing - 1) ? '0 : spacingCnt + 1'b1;
        if (spacingCnt == '0 && int'(pulseCnt) != PulseCount) begin
          CtestPulse <= 1'b1;
          pulseCnt   <= pulseCnt + 1'b1;
        end
        if (windowEnd) begin
          active     <= 1'b0;
          CountWrite <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge Clk) begin
    if (windowEnd) begin
      CountData <= trigNext; // Includes the closing cycle
    end
  end

endmodule

//--- hdl/sCurveScanControl.sv
`timescale 1ns/1ps

module sCurveScanControl (
  input  logic                     Clk,
  input  logic                     reset_n,
  input  logic                     ScanStart,
  input  sCurvePkg::scanSettings_t Settings,
  output sCurvePkg::scConfig_t     Config,
  output logic                     LoadStart,
  input  logic                     LoadDone,
  output logic                     ForceRaz,
  output logic                     PointStart,
  input  logic                     PointDone,
  input  logic                     FifoEmpty,
  output logic                     FifoRead,
  input  sCurvePkg::dataWord_t     FifoData,
  output sCurvePkg::dataWord_t     DataOut,
  output logic                     DataValid,
  input  logic                     DataFull,
  output logic                     ScanDone,
  input  logic                     TransmitDone
);
  import sCurvePkg::*;

  typedef enum logic [4:0] {
    Idle, HeaderOut, ChanSetup, ChanOut, DacSetup, DacOut, ConfigSelect, LoadIssue,
    LoadWait, Suppress, PointIssue, PointWait, FifoCheck, FifoWait, CountOut,
    NextDac, NextChan, TailOut, TailWait, AllDone
  } state_t;

  state_t       state;
  logic [9:0]   dacCode;
  logic [5:0]   testChn;     // Channel under test in the sweep
  logic [63:0]  chanBit;     // Walking ctest bit, moves with maskWin
  logic [191:0] maskWin;     // Three-bit discriminator window
  scConfig_t    cfgSel;      // Frame for the ASIC under test
  logic [2:0]   loadIdx;
  logic [2:0]   targetIdx;
  logic [63:0]  chanSel;
  logic [7:0]   suppressCnt;
  logic [3:0]   tailCnt;

  // DAC bits go out LSB first in the frame
  function automatic logic [9:0] reverseDac(input logic [9:0] code);
    logic [9:0] rev;
    for (int i = 0; i < 10; i++) begin
      rev[i] = code[9-i];
    end
    return rev;
  endfunction

  // Last ASIC in the chain is loaded first
  assign targetIdx = Settings.asicCount - Settings.testAsic - 3'd1;
  assign chanSel   = Settings.singleChannel ? (64'd1 << Settings.testChannel) : chanBit;

  ////////////////////
  // Scan sequencer
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state       <= Idle;
      dacCode     <= '0;
      testChn     <= '0;
      chanBit     <= 64'd1;
      maskWin     <= 192'b111;
      cfgSel      <= '0;
      Config      <= '0;
      loadIdx     <= '0;
      suppressCnt <= '0;
      tailCnt     <= '0;
      LoadStart   <= 1'b0;
      PointStart  <= 1'b0;
      FifoRead    <= 1'b0;
      ForceRaz    <= 1'b0;
      DataOut     <= '0;
      DataValid   <= 1'b0;
      ScanDone    <= 1'b0;
    end else begin
      LoadStart  <= 1'b0;
      PointStart <= 1'b0;
      FifoRead   <= 1'b0;
      DataValid  <= 1'b0;
      case (state)
        Idle: begin
          if (ScanStart) begin
            DataOut <= ScanHeader;
            dacCode <= Settings.startDac;
            testChn <= '0;
            chanBit <= 64'd1;
            maskWin <= 192'b111;
            loadIdx <= '0;
            state   <= HeaderOut;
          end
        end
        HeaderOut: begin
          DataValid <= 1'b1;
          state     <= ChanSetup;
        end
        ChanSetup: begin
          cfgSel.ctestChannels <= Settings.ctestInject ? chanSel : 64'd0;
          if (Settings.unmaskAll) begin
            cfgSel.discriMask <= '1;
            DataOut           <= 16'h43FF;
          end else if (Settings.singleChannel) begin
            cfgSel.discriMask <= 192'b111 << (8'd3 * 8'(Settings.testChannel));
            DataOut           <= {8'h43, 2'b00, Settings.testChannel}; // 'C'
          end else begin
            cfgSel.discriMask <= maskWin;
            DataOut           <= {8'h63, 2'b00, testChn};              // 'c'
          end
          state <= ChanOut;
        end
        ChanOut: begin
          DataValid <= 1'b1;
          state     <= DacSetup;
        end
        DacSetup: begin
          cfgSel.vthDac <= reverseDac(dacCode);
          DataOut       <= {4'hD, 2'b00, dacCode};
          state         <= DacOut;
        end
        DacOut: begin
          DataValid <= 1'b1;
          state     <= ConfigSelect;
        end
        ConfigSelect: begin
          Config <= (loadIdx == targetIdx) ? cfgSel : '0; // Other ASICs get zeros
          state  <= LoadIssue;
        end
        LoadIssue: begin
          if (loadIdx < Settings.asicCount) begin
            LoadStart <= 1'b1;
            ForceRaz  <= 1'b1;
            loadIdx   <= loadIdx + 3'd1;
            state     <= LoadWait;
          end else begin
            loadIdx     <= '0;
            suppressCnt <= '0;
            state       <= Suppress;
          end
        end
        LoadWait: begin
          if (LoadDone) begin
            state <= ConfigSelect;
          end
        end
        Suppress: begin
          if (suppressCnt == Settings.suppressWidth) begin
            ForceRaz <= 1'b0;
            state    <= PointIssue;
          end else begin
            suppressCnt <= suppressCnt + 8'd1;
          end
        end
        PointIssue: begin
          PointStart <= 1'b1;
          state      <= PointWait;
        end
        PointWait: begin
          if (PointDone) begin
            state <= FifoCheck;
          end
        end
        FifoCheck: begin
          if (FifoEmpty) begin
            state <= NextDac;
          end else begin
            FifoRead <= 1'b1;
            state    <= FifoWait;
          end
        end
        FifoWait: state <= CountOut; // FIFO data lands a cycle after the read
        CountOut: begin
          DataOut <= FifoData;
          if (!DataFull) begin
            DataValid <= 1'b1;
            state     <= FifoCheck;
          end
        end
        NextDac: begin
          if (dacCode == Settings.endDac) begin
            dacCode <= Settings.startDac;
            state   <= NextChan;
          end else begin
            dacCode <= dacCode + Settings.dacStep;
            state   <= DacSetup;
          end
        end
        NextChan: begin
          if (Settings.singleChannel || testChn == 6'd63) begin
            DataOut <= ScanTail;
            state   <= TailOut;
          end else begin
            chanBit <= chanBit << 1;
            maskWin <= maskWin << 3;
            testChn <= testChn + 6'd1;
            state   <= ChanSetup;
          end
        end
        TailOut: begin
          DataValid <= 1'b1;
          tailCnt   <= '0;
          state     <= TailWait;
        end
        TailWait: begin
          // Let the tail drain downstream before flagging done
          if (tailCnt == 4'd15) begin
            ScanDone <= 1'b1;
            state    <= AllDone;
          end else begin
            tailCnt <= tailCnt + 4'd1;
          end
        end
        AllDone: begin
          if (TransmitDone) begin
            ScanDone <= 1'b0;
            state    <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  ////////////////////
  // Strobes toward loader and counter are single-cycle
  assert property (@(posedge Clk) disable iff (!reset_n) LoadStart |=> !LoadStart)
    else $error("LoadStart held for two cycles");
  assert property (@(posedge Clk) disable iff (!reset_n) PointStart |=> !PointStart)
    else $error("PointStart held for two cycles");
  // No stream output while the chain is being loaded
  assert property (@(posedge Clk) disable iff (!reset_n)
    (state inside {LoadIssue, LoadWait}) |-> !DataValid)
    else $error("DataValid during chain load");

endmodule

//--- hdl/sCurveScan.sv
`timescale 1ns/1ps

module sCurveScan (
  input  logic                     Clk,
  input  logic                     reset_n,
  input  logic                     ScanStart,
  input  sCurvePkg::scanSettings_t Settings,
  output logic                     ForceRaz,
  output sCurvePkg::dataWord_t     DataOut,
  output logic                     DataValid,
  input  logic                     DataFull,
  output logic                     ScanDone,
  input  logic                     TransmitDone,
  output logic                     ScClk,
  output logic                     ScData,
  output logic                     CtestPulse,
  input  logic [63:0]              Trigger
);
  import sCurvePkg::*;

  scConfig_t asicConfig;
  logic      loadStart;
  logic      loadDone;
  logic      pointStart;
  logic      pointDone;
  logic      countWrite;
  dataWord_t countData;
  logic      fifoRead;
  logic      fifoEmpty;
  dataWord_t fifoData;

  sCurveScanControl iControl (
    .Clk(Clk), .reset_n(reset_n), .ScanStart(ScanStart), .Settings(Settings),
    .Config(asicConfig), .LoadStart(loadStart), .LoadDone(loadDone),
    .ForceRaz(ForceRaz), .PointStart(pointStart), .PointDone(pointDone),
    .FifoEmpty(fifoEmpty), .FifoRead(fifoRead), .FifoData(fifoData),
    .DataOut(DataOut), .DataValid(DataValid), .DataFull(DataFull),
    .ScanDone(ScanDone), .TransmitDone(TransmitDone)
  );

  slowControlLoader iLoader (
    .Clk(Clk), .reset_n(reset_n), .LoadStart(loadStart), .Config(asicConfig),
    .ScClk(ScClk), .ScData(ScData), .LoadDone(loadDone)
  );

  triggerCounter iCounter (
    .Clk(Clk), .reset_n(reset_n), .PointStart(pointStart), .CtestPulse(CtestPulse),
    .Trigger(Trigger), .CountWrite(countWrite), .CountData(countData),
    .PointDone(pointDone)
  );

  // Count words wait here until the controller streams them
  syncFifo #(.payload_t(dataWord_t), .Depth(FifoDepth)) iFifo (
    .Clk(Clk), .reset_n(reset_n), .Write(countWrite), .WriteData(countData),
    .Read(fifoRead), .ReadData(fifoData), .Empty(fifoEmpty), .Full()
  );

endmodule

//--- sim/sCurveScanTb.sv
`timescale 1ns/1ps

module sCurveScanTb;
  import sCurvePkg::*;

  localparam int AsicCount   = 3;
  localparam int TestAsic    = 1;
  localparam int SuppressW   = 20;
  localparam int ChainBits   = AsicCount * ConfigBits;
  localparam int PointCycles = AsicCount * (ConfigBits + 2) + SuppressW +
                               PulseCount * PulseSpacing + 40;
  localparam int CycleLimit  = (4 + 3 + 64) * PointCycles + 2000; // Points of all three scans

  localparam int KindHeader = 0;
  localparam int KindPlain  = 1;
  localparam int KindCount  = 2;
  localparam int KindTail   = 3;

  logic           Clk;
  logic           reset_n;
  logic           ScanStart;
  scanSettings_t  settings;
  logic           ForceRaz;
  dataWord_t      DataOut;
  logic           DataValid;
  logic           DataFull;
  logic           ScanDone;
  logic           TransmitDone;
  logic           ScClk;
  logic           ScData;
  logic           CtestPulse;
  logic [63:0]    Trigger;

  logic [ChainBits-1:0] chain;       // Whole daisy chain, segment 0 at the ScData end
  logic [63:0]          hits;
  dataWord_t            expWords[$];
  int                   expKind[$];
  int                   ptChan[$];   // One entry per scan point, for the chain check
  int                   ptDac[$];
  integer               seed = 32'hf4c4;
  int                   cycle = 0;
  int                   startCycle = 0;
  int                   tailCycle = 0;
  logic                 prevFull = 1'b0;
  logic                 prevRaz = 1'b0;
  logic                 prevDone = 1'b0;
  logic                 prevTx = 1'b0;
  string                testName = "reset";

  sCurveScan i_dut (
    .Clk(Clk), .reset_n(reset_n), .ScanStart(ScanStart), .Settings(settings),
    .ForceRaz(ForceRaz), .DataOut(DataOut), .DataValid(DataValid), .DataFull(DataFull),
    .ScanDone(ScanDone), .TransmitDone(TransmitDone), .ScClk(ScClk), .ScData(ScData),
    .CtestPulse(CtestPulse), .Trigger(Trigger)
  );

  initial begin
    Clk = 1'b0;
    forever #2 Clk = ~Clk;
  end

  ////////////////////
  // Error reporting
  task automatic stopRun();
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic reportMismatch(input string what, input string expStr, input string actStr);
    $display("** Error [%s] %s: expected %s, actual %s", testName, what, expStr, actStr);
    stopRun();
  endtask

  task automatic reportFailure(input string msg);
    $display("Error in test %s: %s", testName, msg);
    stopRun();
  endtask

  ////////////////////
  // ASIC chain model
  always @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      chain <= '0;
    end else if (ScClk) begin
      chain <= {chain[ChainBits-2:0], ScData};
    end
  end

  // Channels that fire for one test pulse, ORed over all ASICs
  function automatic logic [63:0] chainHits(input logic [ChainBits-1:0] ch);
    scConfig_t   seg;
    logic [9:0]  dac;
    logic [63:0] fired;
    fired = '0;
    for (int k = 0; k < AsicCount; k++) begin
      seg = ch[k*ConfigBits +: ConfigBits];
      dac = {<<{seg.vthDac}};  // Undo the wire order
      for (int c = 0; c < 64; c++) begin
        if ((seg.ctestChannels[c] || !settings.ctestInject) && (&seg.discriMask[3*c +: 3]) &&
            int'(dac) < 300 + 4 * c) begin
          fired[c] = 1'b1;
        end
      end
    end
    return fired;
  endfunction

  initial begin
    Trigger = '0;
    forever begin
      @(posedge Clk);
      hits = CtestPulse ? chainHits(chain) : 64'd0;
      #1;
      Trigger = hits;  // Trigger answers in the cycle after the pulse
    end
  end

  initial begin
    DataFull = 1'b0;
    forever begin
      @(posedge Clk);
      #1;
      DataFull = (($random(seed) & 3) == 0);  // Busy about a quarter of the time
    end
  end

  ////////////////////
  // Expected stream from the scan rules
  function automatic dataWord_t expectCount(input int chan, input int code);
    logic hit;
    hit = 1'b0;
    for (int c = 0; c < 64; c++) begin
      if ((!settings.ctestInject || c == chan) && (settings.unmaskAll || c == chan) &&
          300 + 4 * c > code) begin
        hit = 1'b1;
      end
    end
    return hit ? dataWord_t'(PulseCount) : 16'd0;
  endfunction

  function automatic scConfig_t expectConfig(input int chan, input int code);
    scConfig_t  cfg;
    logic [9:0] dacBits;
    dacBits           = 10'(code);
    cfg.ctestChannels = settings.ctestInject ? (64'd1 << chan) : 64'd0;
    cfg.vthDac        = {<<{dacBits}};
    cfg.discriMask    = settings.unmaskAll ? {192{1'b1}} : (192'b111 << (3 * chan));
    return cfg;
  endfunction

  task automatic pushWord(input dataWord_t word, input int kind);
    expWords.push_back(word);
    expKind.push_back(kind);
  endtask

  task automatic buildExpected();
    int   chan;
    int   code;
    logic last;
    pushWord(ScanHeader, KindHeader);
    for (int i = 0; i < (settings.singleChannel ? 1 : 64); i++) begin
      chan = settings.singleChannel ? int'(settings.testChannel) : i;
      if (settings.unmaskAll) pushWord(16'h43FF, KindPlain);
      else if (settings.singleChannel) pushWord({8'h43, 2'b00, 6'(chan)}, KindPlain);
      else pushWord({8'h63, 2'b00, 6'(chan)}, KindPlain);
      code = int'(settings.startDac);
      last = 1'b0;
      while (!last) begin
        pushWord({4'hD, 2'b00, 10'(code)}, KindPlain);
        pushWord(expectCount(chan, code), KindCount);
        ptChan.push_back(chan);
        ptDac.push_back(code);
        last = (code == int'(settings.endDac));
        code = code + int'(settings.dacStep);
      end
    end
    pushWord(ScanTail, KindTail);
  endtask

  ////////////////////
  // Stream, chain and done monitor
  task automatic checkWord();
    dataWord_t exp;
    int        kind;
    if (expWords.size() == 0) begin
      reportFailure("DataValid pulsed with no word left to expect");
    end else begin
      exp  = expWords.pop_front();
      kind = expKind.pop_front();
      assert (DataOut == exp)
        else reportMismatch("stream word", $sformatf("%h", exp), $sformatf("%h", DataOut));
      assert (!(kind == KindCount && prevFull))
        else reportFailure("count word sent although DataFull was high");
      if (kind == KindHeader) begin
        assert (cycle == startCycle + 2)
          else reportMismatch("header cycle", $sformatf("%0d", startCycle + 2),
                              $sformatf("%0d", cycle));
      end
      if (kind == KindTail) tailCycle = cycle;
    end
  endtask

  task automatic checkChain();
    scConfig_t seg;
    scConfig_t expSeg;
    int        chan;
    int        code;
    if (ptChan.size() == 0) begin
      reportFailure("chain was loaded with no scan point left to expect");
    end else begin
      chan = ptChan.pop_front();
      code = ptDac.pop_front();
      for (int k = 0; k < AsicCount; k++) begin
        seg    = chain[k*ConfigBits +: ConfigBits];
        expSeg = (k == TestAsic) ? expectConfig(chan, code) : '0; // Others stay blank
        assert (seg == expSeg)
          else reportMismatch($sformatf("ASIC %0d config", k), $sformatf("%h", expSeg),
                              $sformatf("%h", seg));
      end
    end
  endtask

  always @(posedge Clk) begin
    cycle = cycle + 1;
    if (cycle > CycleLimit) reportFailure("timeout, the scans did not finish in time");
    if (reset_n) begin
      if (ScanStart) startCycle = cycle;
      if (DataValid) checkWord();
      if (prevRaz && !ForceRaz) checkChain();  // Suppression over, chain is settled
      if (!prevDone && ScanDone) begin
        assert (cycle == tailCycle + 16)
          else reportMismatch("ScanDone cycle", $sformatf("%0d", tailCycle + 16),
                              $sformatf("%0d", cycle));
        assert (expWords.size() == 0)
          else reportFailure("ScanDone rose while stream words were still missing");
      end
      if (prevDone && !ScanDone) begin
        assert (prevTx) else reportFailure("ScanDone fell without TransmitDone");
      end
    end
    prevFull = DataFull;
    prevRaz  = ForceRaz;
    prevDone = ScanDone;
    prevTx   = TransmitDone;
  end

  assert property (@(posedge Clk) disable iff (!reset_n) ScanDone |-> !DataValid)
    else reportFailure("DataValid while ScanDone is high");
  assert property (@(posedge Clk) disable iff (!reset_n) CtestPulse |-> !ForceRaz)
    else reportFailure("test pulse fired inside the suppression window");
  assert property (@(posedge Clk) disable iff (!reset_n) ScClk |-> ForceRaz)
    else reportFailure("chain loaded while ForceRaz was low");

  ////////////////////
  // Stimulus
  function automatic scanSettings_t makeSettings(input logic single, input int chan,
                                                 input logic ctest, input logic all,
                                                 input int startCode, input int endCode,
                                                 input int step);
    scanSettings_t s;
    s.singleChannel = single;
    s.testChannel   = 6'(chan);
    s.ctestInject   = ctest;
    s.unmaskAll     = all;
    s.startDac      = 10'(startCode);
    s.endDac        = 10'(endCode);
    s.dacStep       = 10'(step);
    s.asicCount     = 3'(AsicCount);
    s.testAsic      = 3'(TestAsic);
    s.suppressWidth = 8'(SuppressW);
    return s;
  endfunction

  task automatic runScan(input string name, input scanSettings_t s);
    testName = name;
    @(posedge Clk);
    #1;
    settings = s;
    buildExpected();
    @(posedge Clk);
    #1;
    ScanStart = 1'b1;
    @(posedge Clk);
    #1;
    ScanStart = 0;
    while (!ScanDone) @(posedge Clk);
    repeat (4) @(posedge Clk);       // Done level must hold meanwhile
    #1;
    TransmitDone = 1'b1;
    @(posedge Clk);
    #1;
    TransmitDone = 1'b0;
    while (ScanDone) @(posedge Clk);
    assert (expWords.size() == 0 && ptChan.size() == 0)
      else reportFailure("scan ended with words or points still expected");
    $display("Scan %s finished at cycle %0d", name, cycle);
  endtask

  initial begin
    reset_n      = 1'b0;
    ScanStart    = 1'b0;
    TransmitDone = 1'b0;
    settings     = '0;
    repeat (8) @(posedge Clk);
    #1;
    reset_n = 1'b1;
    runScan("single channel", makeSettings(1'b1, 5, 1'b1, 1'b0, 290, 320, 10));
    runScan("unmask all", makeSettings(1'b1, 0, 1'b0, 1'b1, 540, 560, 10));
    runScan("channel sweep", makeSettings(1'b0, 0, 1'b1, 1'b0, 400, 400, 1));
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- sCurveScan.f
hdl/sCurvePkg.sv
hdl/syncFifo.sv
hdl/slowControlLoader.sv
hdl/triggerCounter.sv
hdl/sCurveScanControl.sv
hdl/sCurveScan.sv
sim/sCurveScanTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the S-curve scan testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sCurveScan.f --top-module sCurveScanTb \
  -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi
exit 0
